/* Makefile */
# Verilator build and run of the clock and reset testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_mcoi_clk_rst_system
FILELIST = filelist.f

SOURCES  = $(shell cat $(FILELIST))
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* design/link_monitor.sv */
/*
   Link supervisor, runs in the 100 MHz system clock domain.
   los_i and pll_locked_i are raw asynchronous levels and pass two flops
   before use. No debounce is done beyond the settle timer.
   From clean inputs ready_o rises SETTLE_LEN+3 to SETTLE_LEN+4 cycles later.
   los_count_o counts only losses out of ST_RUN and saturates at 255.
   SETTLE_LEN must be at least 1.
*/
`default_nettype none

module link_monitor import mcoi_clk_pkg::*, mcoi_link_pkg::*; #(
   parameter int unsigned SETTLE_LEN = SETTLE_LEN_DEF
) (
   input  logic       clk_ik,
   input  logic       rst_n_i,
   input  logic       los_i,
   input  logic       pll_locked_i,
   output logic       rst_req_o,
   output logic       ready_o,
   output los_count_t los_count_o
);

   // synchronizer pipes, bit 1 is the one the FSM reads
   logic [1:0]  los_sync_q;
   logic [1:0]  lock_sync_q;
   logic        los_s;
   logic        lock_s;

   link_state_t state_q;
   filt_cnt_t   settle_cnt_q;
   los_count_t  los_count_q;
   // one cycle strobe when a running link goes down
   logic        loss_evt;

   // --------------------------------------------------
   // input synchronizers
   // --------------------------------------------------
   // los resets high and lock low, so the link starts as not usable
   always_ff @(posedge clk_ik or negedge rst_n_i) begin
      if (!rst_n_i) begin
         los_sync_q  <= 2'b11;
         lock_sync_q <= 2'b00;
      end else begin
         los_sync_q  <= {los_sync_q[0], los_i};
         lock_sync_q <= {lock_sync_q[0], pll_locked_i};
      end
   end

   assign los_s  = los_sync_q[1];
   assign lock_s = lock_sync_q[1];

   // --------------------------------------------------
   // startup and recovery FSM
   // --------------------------------------------------
   // lock loss always wins over los and falls back furthest
   always_ff @(posedge clk_ik or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q      <= ST_WAIT_LOCK;
         settle_cnt_q <= '0;
      end else begin
         case (state_q)
            ST_WAIT_LOCK: begin
               settle_cnt_q <= '0;
               if (lock_s) begin
                  state_q <= ST_WAIT_LINK;
               end
            end
            ST_WAIT_LINK: begin
               settle_cnt_q <= '0;
               if (!lock_s) begin
                  state_q <= ST_WAIT_LOCK;
               end else if (!los_s) begin
                  state_q <= ST_SETTLE;
               end
            end
            ST_SETTLE: begin
               if (!lock_s) begin
                  state_q <= ST_WAIT_LOCK;
               end else if (los_s) begin
                  state_q <= ST_WAIT_LINK;
               end else if (settle_cnt_q == filt_cnt_t'(SETTLE_LEN - 1)) begin
                  state_q <= ST_RUN;
               end else begin
                  settle_cnt_q <= settle_cnt_q + filt_cnt_t'(1);
               end
            end
            ST_RUN: begin
               settle_cnt_q <= '0;
               if (!lock_s) begin
                  state_q <= ST_WAIT_LOCK;
               end else if (los_s) begin
                  state_q <= ST_WAIT_LINK;
               end
            end
            default: begin
               state_q      <= ST_WAIT_LOCK;
               settle_cnt_q <= '0;
            end
         endcase
      end
   end

   // --------------------------------------------------
   // loss counter
   // --------------------------------------------------
   // either input going bad in ST_RUN counts as one loss
   assign loss_evt = (state_q == ST_RUN) && (los_s || !lock_s);

   always_ff @(posedge clk_ik or negedge rst_n_i) begin
      if (!rst_n_i) begin
         los_count_q <= '0;
      end else if (loss_evt && (los_count_q != LOS_COUNT_MAX)) begin
         los_count_q <= los_count_q + los_count_t'(1);
      end
   end

   // outputs decode straight from state
   assign ready_o     = (state_q == ST_RUN);
   assign rst_req_o   = (state_q != ST_RUN);
   assign los_count_o = los_count_q;

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   // ready only after a full settle window of clean synchronized inputs,
   // first sample is the one that left ST_WAIT_LINK
   a_ready_after_settle : assert property (
      @(posedge clk_ik) disable iff (!rst_n_i)
      $rose(ready_o) |-> $past(lock_s && !los_s, 1) &&
                         $past(lock_s && !los_s, SETTLE_LEN + 1)
   ) else $error("ready_o rose without a clean settle window");

   // the count only grows between board resets
   a_count_monotonic : assert property (
      @(posedge clk_ik) disable iff (!rst_n_i)
      los_count_o >= $past(los_count_o)
   ) else $error("los_count_o decreased outside reset");

endmodule : link_monitor

`default_nettype wire

/* design/mcoi_clk_pkg.sv */
/*
   Clock-domain definitions shared by the reset filters and the link supervisor.
   The filter counter is 16 bits wide, so FILTER_LEN and SETTLE_LEN
   must stay below 65535. The default lengths suit the board clocks.
   Simulation normally overrides them with much smaller values.
*/
`default_nettype none

package mcoi_clk_pkg;

   // --------------------------------------------------
   // widths
   // --------------------------------------------------

   // one counter width serves both the release filter and the settle timer
   localparam int unsigned FILT_CNT_W = 16;

   typedef logic [FILT_CNT_W-1:0] filt_cnt_t;

   // --------------------------------------------------
   // default lengths in cycles of the relevant clock
   // --------------------------------------------------

   // clean cycles a domain reset waits before release
   localparam int unsigned FILTER_LEN_DEF = 16;

   // clean 100 MHz cycles before the link counts as ready
   localparam int unsigned SETTLE_LEN_DEF = 64;

endpackage : mcoi_clk_pkg

`default_nettype wire

/* design/mcoi_clk_rst_system.sv */
/*
   Clock and reset block of the front-end controller.
   The three clocks arrive already buffered. Input buffers and the PLL
   are outside this block, and pll_locked_i comes from that PLL.
   One active-high reset per clock domain follows the link supervisor.
   Each reset releases FILTER_LEN+3 cycles of its own clock after the
   request drops, and rises within about 6 of them after a loss.
*/
`default_nettype none

module mcoi_clk_rst_system import mcoi_clk_pkg::*, mcoi_link_pkg::*; #(
   parameter int unsigned FILTER_LEN = FILTER_LEN_DEF,
   parameter int unsigned SETTLE_LEN = SETTLE_LEN_DEF
) (
   // clocks
   input  logic       clk100m_ik,
   input  logic       clk120m_ik,
   input  logic       clk40m_ik,
   // board power-on reset
   input  logic       rst_n_i,
   // raw link status
   input  logic       los_i,
   input  logic       pll_locked_i,
   // domain resets, active high
   output logic       rst100m_o,
   output logic       rst120m_o,
   output logic       rst40m_o,
   // supervisor status
   output logic       ready_o,
   output los_count_t los_count_o
);

   // system reset request, 100 MHz domain level
   logic rst_req;

   // --------------------------------------------------
   // link supervisor
   // --------------------------------------------------
   link_monitor #(
      .SETTLE_LEN (SETTLE_LEN)
   ) u_link_monitor (
      .clk_ik       (clk100m_ik),
      .rst_n_i      (rst_n_i),
      .los_i        (los_i),
      .pll_locked_i (pll_locked_i),
      .rst_req_o    (rst_req),
      .ready_o      (ready_o),
      .los_count_o  (los_count_o)
   );

   // --------------------------------------------------
   // per-domain reset filters
   // --------------------------------------------------
   // the 100 MHz copy still resynchronizes, which keeps all three aligned
   reset_sync_filter #(
      .FILTER_LEN (FILTER_LEN)
   ) u_rst100m_sync (
      .clk_ik    (clk100m_ik),
      .rst_n_i   (rst_n_i),
      .rst_req_i (rst_req),
      .rst_o     (rst100m_o)
   );

   reset_sync_filter #(
      .FILTER_LEN (FILTER_LEN)
   ) u_rst120m_sync (
      .clk_ik    (clk120m_ik),
      .rst_n_i   (rst_n_i),
      .rst_req_i (rst_req),
      .rst_o     (rst120m_o)
   );

   // slowest domain, its release sets when the whole board is out of reset
   reset_sync_filter #(
      .FILTER_LEN (FILTER_LEN)
   ) u_rst40m_sync (
      .clk_ik    (clk40m_ik),
      .rst_n_i   (rst_n_i),
      .rst_req_i (rst_req),
      .rst_o     (rst40m_o)
   );

endmodule : mcoi_clk_rst_system

`default_nettype wire

/* design/mcoi_link_pkg.sv */
/*
   Link supervisor definitions.
   The state encoding is fixed at 2 bits. ST_RUN is the only state
   in which the system reset request is released.
   The loss counter saturates and never wraps.
*/
`default_nettype none

package mcoi_link_pkg;

   // --------------------------------------------------
   // supervisor FSM
   // --------------------------------------------------
   typedef enum logic [1:0] {
      ST_WAIT_LOCK = 2'd0,   // PLL not locked yet
      ST_WAIT_LINK = 2'd1,   // locked, optical link still lost
      ST_SETTLE    = 2'd2,   // both clean, timing the settle period
      ST_RUN       = 2'd3    // link up, resets released
   } link_state_t;

   // --------------------------------------------------
   // link loss counter
   // --------------------------------------------------
   localparam int unsigned LOS_COUNT_W = 8;

   typedef logic [LOS_COUNT_W-1:0] los_count_t;

   // saturation value, all ones
   localparam los_count_t LOS_COUNT_MAX = '1;

endpackage : mcoi_link_pkg

`default_nettype wire

/* design/reset_sync_filter.sv */
/*
   Reset request synchronizer and release filter for one clock domain.
   rst_req_i may be asynchronous to clk_ik. The domain reset rises three
   edges after the request is sampled. It falls only after FILTER_LEN
   clean synchronized cycles, on edge FILTER_LEN+3.
   rst_n_i forces rst_o high asynchronously. FILTER_LEN must be at least 1.
*/
`default_nettype none

module reset_sync_filter import mcoi_clk_pkg::*; #(
   parameter int unsigned FILTER_LEN = FILTER_LEN_DEF
) (
   input  logic clk_ik,
   input  logic rst_n_i,
   input  logic rst_req_i,
   output logic rst_o
);

   // two synchronizer stages, index 1 is the safe copy
   logic [1:0] sync_q;
   // clean cycles seen since the request was last high
   filt_cnt_t  clean_cnt_q;
   logic       rst_q;

   // --------------------------------------------------
   // synchronizer
   // --------------------------------------------------
   // comes out of board reset with the request assumed active
   always_ff @(posedge clk_ik or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sync_q <= 2'b11;
      end else begin
         sync_q <= {sync_q[0], rst_req_i};
      end
   end

   // --------------------------------------------------
   // release filter
   // --------------------------------------------------
   // a high sample asserts at once and restarts the clean count
   // the reset drops one edge after the count reaches FILTER_LEN
   always_ff @(posedge clk_ik or negedge rst_n_i) begin
      if (!rst_n_i) begin
         clean_cnt_q <= '0;
         rst_q       <= 1'b1;
      end else if (sync_q[1]) begin
         clean_cnt_q <= '0;
         rst_q       <= 1'b1;
      end else if (clean_cnt_q < filt_cnt_t'(FILTER_LEN)) begin
         clean_cnt_q <= clean_cnt_q + filt_cnt_t'(1);
      end else begin
         rst_q <= 1'b0;
      end
   end

   assign rst_o = rst_q;

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   // release needs the synchronized request low both just before the fall
   // and at the start of the filter window
   a_release_after_clean : assert property (
      @(posedge clk_ik) disable iff (!rst_n_i)
      $fell(rst_o) |-> !$past(sync_q[1], 1) && !$past(sync_q[1], FILTER_LEN + 1)
   ) else $error("domain reset released while the request was still active");

endmodule : reset_sync_filter

`default_nettype wire

/* filelist.f */
design/mcoi_clk_pkg.sv
design/mcoi_link_pkg.sv
design/reset_sync_filter.sv
design/link_monitor.sv
design/mcoi_clk_rst_system.sv
verification/clk_rst_checker.sv
verification/tb_mcoi_clk_rst_system.sv

/* verification/clk_rst_checker.sv */
/*
   Testbench checker for the clock and reset block.
   Row results are compared on the falling 100 MHz edge while check_i is high.
   Each domain reset is watched in its own clock by a small watcher.
   Release and raise limits are counted in the domain's own cycles.
*/
`default_nettype none

module domain_reset_watch #(
   parameter int unsigned FILTER_LEN = 4,
   parameter string       NAME       = "domain"
) (
   input  wire logic clk_ik,
   input  wire logic rst_n_i,
   input  wire logic ready_i,
   input  wire logic rst_i,
   output int        errors_o
);
   timeunit 1ns;
   timeprecision 100ps;

   int unsigned hi_run = 0;
   int unsigned lo_run = 0;
   logic        rst_prev = 1'b1;
   int          err_q = 0;

   // rst_i is sampled before this edge updates it
   always @(posedge clk_ik) begin
      if (!rst_n_i) begin
         hi_run   <= 0;
         lo_run   <= 0;
         rst_prev <= 1'b1;
      end else begin
         hi_run   <= ready_i ? hi_run + 1 : 0;
         lo_run   <= ready_i ? 0 : lo_run + 1;
         rst_prev <= rst_i;
         // a release must follow a rise of ready_o
         if (rst_prev && !rst_i && !ready_i) begin
            err_q++;
            $display("%s reset released at %0t while ready_o was low", NAME, $time);
         end
         if (hi_run >= FILTER_LEN + 4 && rst_i) begin
            err_q++;
            $display("%s reset still high at %0t, %0d cycles after ready_o rose",
                     NAME, $time, hi_run);
         end
         if (lo_run > 6 && !rst_i) begin
            err_q++;
            $display("%s reset not raised at %0t, %0d cycles after ready_o fell",
                     NAME, $time, lo_run);
         end
         // ready_o just came back, the loss before it must have raised the reset
         if (ready_i && hi_run == 0 && lo_run > 0 && !rst_i) begin
            err_q++;
            $display("%s reset was low at %0t when ready_o rose", NAME, $time);
         end
      end
   end

   assign errors_o = err_q;

endmodule : domain_reset_watch

module clk_rst_checker import mcoi_link_pkg::*; #(
   parameter int unsigned FILTER_LEN = 4
) (
   input  wire logic       clk100m_ik,
   input  wire logic       clk120m_ik,
   input  wire logic       clk40m_ik,
   input  wire logic       rst_n_i,
   input  wire logic       ready_i,
   input  wire los_count_t los_count_i,
   input  wire logic       rst100m_i,
   input  wire logic       rst120m_i,
   input  wire logic       rst40m_i,
   input  wire logic       check_i,
   input  wire logic       exp_ready_i,
   input  wire los_count_t exp_count_i,
   input  wire logic       hold_low_i,
   output int              value_errors_o,
   output int              timing_errors_o
);
   timeunit 1ns;
   timeprecision 100ps;

   int val_err = 0;
   int err100;
   int err120;
   int err40;

   // --------------------------------------------------
   // row results, 100 MHz domain only
   // --------------------------------------------------
   always @(negedge clk100m_ik) begin
      if (check_i && ready_i !== exp_ready_i) begin
         val_err++;
         $display("error at %0t: ready_o expected %0b actual %0b",
                  $time, exp_ready_i, ready_i);
      end
      if (check_i && los_count_i !== exp_count_i) begin
         val_err++;
         $display("error at %0t: los_count_o expected %0d actual %0d",
                  $time, exp_count_i, los_count_i);
      end
      // settle glitches must keep the link down every cycle
      if (hold_low_i && ready_i !== 1'b0) begin
         val_err++;
         $display("error at %0t: ready_o expected 0 actual %0b", $time, ready_i);
      end
   end

   // --------------------------------------------------
   // per-domain reset watchers
   // --------------------------------------------------
   domain_reset_watch #(.FILTER_LEN(FILTER_LEN), .NAME("100 MHz")) u_watch100 (
      .clk_ik(clk100m_ik), .rst_n_i(rst_n_i), .ready_i(ready_i),
      .rst_i(rst100m_i), .errors_o(err100)
   );
   domain_reset_watch #(.FILTER_LEN(FILTER_LEN), .NAME("120 MHz")) u_watch120 (
      .clk_ik(clk120m_ik), .rst_n_i(rst_n_i), .ready_i(ready_i),
      .rst_i(rst120m_i), .errors_o(err120)
   );
   domain_reset_watch #(.FILTER_LEN(FILTER_LEN), .NAME("40 MHz")) u_watch40 (
      .clk_ik(clk40m_ik), .rst_n_i(rst_n_i), .ready_i(ready_i),
      .rst_i(rst40m_i), .errors_o(err40)
   );

   assign value_errors_o  = val_err;
   assign timing_errors_o = err100 + err120 + err40;

endmodule : clk_rst_checker

`default_nettype wire

/* verification/tb_mcoi_clk_rst_system.sv */
/*
   Testbench for the clock and reset block, FILTER_LEN 4 and SETTLE_LEN 8.
   Each table row holds los and lock for a number of 100 MHz cycles and is
   checked at its end. Glitch rows place one-cycle los pulses by LFSR.
   The saturation row counts loss iterations instead of cycles.
*/
`default_nettype none

module tb_mcoi_clk_rst_system import mcoi_link_pkg::*;;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int unsigned FILTER_LEN = 4;
   localparam int unsigned SETTLE_LEN = 8;
   localparam int unsigned NUM_ROWS   = 15;
   // one saturation loop, short enough that no domain reset releases
   localparam int unsigned SAT_CLEAN  = 11;
   localparam int unsigned SAT_LOS    = 3;
   localparam logic [1:0]  K_LEVEL    = 2'd0;
   localparam logic [1:0]  K_GLITCH   = 2'd1;
   localparam logic [1:0]  K_SAT      = 2'd2;

   typedef struct packed {
      logic [1:0]  kind;
      logic        los;
      logic        lock;
      logic [15:0] hold;
      logic        chk;
      logic        exp_ready;
      los_count_t  exp_count;
   } row_t;

   logic clk100m_ik = 1'b0;
   logic clk120m_ik = 1'b0;
   logic clk40m_ik  = 1'b0;
   logic rst_n_i, los_i, pll_locked_i;
   logic rst100m_o, rst120m_o, rst40m_o, ready_o;
   los_count_t los_count_o;
   logic check, exp_ready, hold_low;
   los_count_t exp_count;
   int value_errors, timing_errors;
   row_t rows [NUM_ROWS];
   logic [15:0] lfsr;
   int unsigned cycle_cnt = 0;
   int unsigned cycle_limit = 32'hffff_ffff;

   always #50 clk100m_ik = ~clk100m_ik;
   always #40 clk120m_ik = ~clk120m_ik;
   always #120 clk40m_ik = ~clk40m_ik;

   mcoi_clk_rst_system #(.FILTER_LEN(FILTER_LEN), .SETTLE_LEN(SETTLE_LEN)) UUT (
      .clk100m_ik(clk100m_ik), .clk120m_ik(clk120m_ik), .clk40m_ik(clk40m_ik),
      .rst_n_i(rst_n_i), .los_i(los_i), .pll_locked_i(pll_locked_i),
      .rst100m_o(rst100m_o), .rst120m_o(rst120m_o), .rst40m_o(rst40m_o),
      .ready_o(ready_o), .los_count_o(los_count_o)
   );

   clk_rst_checker #(.FILTER_LEN(FILTER_LEN)) u_checker (
      .clk100m_ik(clk100m_ik), .clk120m_ik(clk120m_ik), .clk40m_ik(clk40m_ik),
      .rst_n_i(rst_n_i), .ready_i(ready_o), .los_count_i(los_count_o),
      .rst100m_i(rst100m_o), .rst120m_i(rst120m_o), .rst40m_i(rst40m_o),
      .check_i(check), .exp_ready_i(exp_ready), .exp_count_i(exp_count),
      .hold_low_i(hold_low), .value_errors_o(value_errors),
      .timing_errors_o(timing_errors)
   );

   // 16-bit Fibonacci LFSR, taps 16 14 13 11, new bit enters at bit 0
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // cycles spent by the whole table, two extra per row for the check
   function automatic int unsigned stimulus_cycles();
      int unsigned sum;
      sum = 0;
      foreach (rows[i]) begin
         if (rows[i].kind == K_SAT) begin
            sum += 32'(rows[i].hold) * (SAT_CLEAN + SAT_LOS);
         end else begin
            sum += 32'(rows[i].hold);
         end
         sum += 2;
      end
      return sum;
   endfunction

   task automatic apply_row(input row_t r);
      logic [1:0] pos;
      pos = 2'd0;
      if (r.kind == K_SAT) begin
         for (int i = 0; i < 32'(r.hold); i++) begin
            @(posedge clk100m_ik);
            los_i        <= 1'b0;
            pll_locked_i <= r.lock;
            repeat (SAT_CLEAN) @(posedge clk100m_ik);
            los_i <= 1'b1;
            repeat (SAT_LOS - 1) @(posedge clk100m_ik);
         end
      end else if (r.kind == K_GLITCH) begin
         for (int c = 0; c < 32'(r.hold); c++) begin
            // one glitch in every window of four cycles
            if (c % 4 == 0) begin
               lfsr   = lfsr_next(lfsr);
               pos[0] = lfsr[0];
               lfsr   = lfsr_next(lfsr);
               pos[1] = lfsr[0];
            end
            @(posedge clk100m_ik);
            los_i        <= (c % 4 == int'(pos));
            pll_locked_i <= r.lock;
            hold_low     <= 1'b1;
         end
      end else begin
         @(posedge clk100m_ik);
         los_i        <= r.los;
         pll_locked_i <= r.lock;
         repeat (32'(r.hold) - 1) @(posedge clk100m_ik);
      end
      @(posedge clk100m_ik);
      los_i     <= r.los;
      hold_low  <= 1'b0;
      check     <= r.chk;
      exp_ready <= r.exp_ready;
      exp_count <= r.exp_count;
      @(posedge clk100m_ik);
      check <= 1'b0;
   endtask

   // ends a stuck run
   always @(posedge clk100m_ik) begin
      cycle_cnt++;
      if (cycle_cnt >= cycle_limit) begin
         $display("timeout: stimulus did not finish within %0d cycles", cycle_limit);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   initial begin
      rst_n_i      = 1'b0;
      los_i        = 1'b1;
      pll_locked_i = 1'b0;
      check        = 1'b0;
      hold_low     = 1'b0;
      exp_ready    = 1'b0;
      exp_count    = '0;
      lfsr         = 16'd7171;
      // kind, los, lock, hold, check, ready, count
      rows = '{
         '{K_LEVEL,  1'b1, 1'b0, 16'd20,  1'b1, 1'b0, 8'd0},
         '{K_LEVEL,  1'b0, 1'b0, 16'd20,  1'b1, 1'b0, 8'd0},
         '{K_LEVEL,  1'b0, 1'b1, 16'd38,  1'b1, 1'b1, 8'd0},
         '{K_LEVEL,  1'b1, 1'b1, 16'd3,   1'b0, 1'b0, 8'd0},
         '{K_LEVEL,  1'b0, 1'b1, 16'd38,  1'b1, 1'b1, 8'd1},
         '{K_LEVEL,  1'b1, 1'b1, 16'd20,  1'b1, 1'b0, 8'd2},
         '{K_GLITCH, 1'b0, 1'b1, 16'd40,  1'b1, 1'b0, 8'd2},
         '{K_LEVEL,  1'b0, 1'b1, 16'd38,  1'b1, 1'b1, 8'd2},
         '{K_LEVEL,  1'b0, 1'b0, 16'd20,  1'b1, 1'b0, 8'd3},
         '{K_LEVEL,  1'b0, 1'b1, 16'd5,   1'b0, 1'b0, 8'd3},
         '{K_LEVEL,  1'b0, 1'b0, 16'd20,  1'b1, 1'b0, 8'd3},
         '{K_LEVEL,  1'b0, 1'b1, 16'd38,  1'b1, 1'b1, 8'd3},
         '{K_SAT,    1'b0, 1'b1, 16'd260, 1'b0, 1'b0, 8'd255},
         '{K_LEVEL,  1'b1, 1'b1, 16'd20,  1'b1, 1'b0, 8'd255},
         '{K_LEVEL,  1'b0, 1'b1, 16'd38,  1'b1, 1'b1, 8'd255}
      };
      cycle_limit = stimulus_cycles() + 200 + 8;
      repeat (8) @(posedge clk100m_ik);
      rst_n_i <= 1'b1;
      foreach (rows[i]) begin
         apply_row(rows[i]);
      end
      repeat (4) @(posedge clk100m_ik);
      $display("errors: value %0d, timing %0d", value_errors, timing_errors);
      if (value_errors == 0 && timing_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule : tb_mcoi_clk_rst_system

`default_nettype wire
